//--- logic/cpuPkg.sv
package cpuPkg;

  localparam int dataWidth = 16;
  localparam int memDepth = 256;
  localparam int memAddrW = $clog2(memDepth);  // Low address bits that index a memory
  localparam logic [dataWidth-1:0] outPortAddr = 16'hFFFF;

  // Bit positions inside flagWe and the flag register
  localparam int flagZr = 2;
  localparam int flagOv = 1;
  localparam int flagNe = 0;

  typedef enum logic [3:0] {
    ADD = 4'h0,
    SUB = 4'h1,
    AND = 4'h2,
    NOR = 4'h3,
    SLL = 4'h4,
    SRL = 4'h5,
    SRA = 4'h6,
    LW  = 4'h7,
    SW  = 4'h8,
    LHB = 4'h9,
    LLB = 4'hA,
    B   = 4'hB,
    JAL = 4'hC,
    JR  = 4'hD,
    HLT = 4'hF
  } opcodeT;

  typedef enum logic [2:0] {
    NEQ = 3'd0,
    EQ  = 3'd1,
    GT  = 3'd2,
    LT  = 3'd3,
    GTE = 3'd4,
    LTE = 3'd5,
    OVF = 3'd6,
    UNC = 3'd7
  } condT;

  typedef struct packed {
    opcodeT op;
    condT cond;
    logic [3:0] rd;
    logic [3:0] rs;
    logic [3:0] rt;
    logic [dataWidth-1:0] imm;  // Already extended or positioned
    logic regWe;
    logic memRe;
    logic memWe;
    logic [2:0] flagWe;         // {zero, overflow, negative}
    logic halt;
  } ctrlT;

  typedef struct packed {
    logic valid;
    logic [dataWidth-1:0] data;
  } outPortT;

endpackage

//--- logic/programCounter.sv
module programCounter
  import cpuPkg::*;
(
  input  logic clk,
  input  logic rstN,
  input  logic run,
  input  logic halt,
  input  logic [dataWidth-1:0] nextPc,
  output logic [dataWidth-1:0] pc,
  output logic running
);

  always_ff @(posedge clk) begin
    if (!rstN) begin
      running <= 1'b0;
      pc <= '0;
    end else if (!running) begin
      if (run) begin  // Start over from address 0
        running <= 1'b1;
        pc <= '0;
      end
    end else if (halt) begin
      running <= 1'b0;
      pc <= pc + 1'b1;  // Parks just past the HLT
    end else begin
      pc <= nextPc;
    end
  end

endmodule

//--- logic/instrMem.sv
module instrMem
  import cpuPkg::*;
(
  input  logic clk,
  input  logic we,
  input  logic [dataWidth-1:0] waddr,
  input  logic [dataWidth-1:0] wdata,
  input  logic [dataWidth-1:0] addr,
  output logic [dataWidth-1:0] instr
);

  logic [dataWidth-1:0] mem [memDepth];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr[memAddrW-1:0]] <= wdata;
    end
  end

  assign instr = mem[addr[memAddrW-1:0]];  // Async fetch

endmodule

//--- logic/decoder.sv
module decoder
  import cpuPkg::*;
(
  input  logic [dataWidth-1:0] instr,
  output ctrlT ctrl
);

  always_comb begin
    ctrl = '0;
    ctrl.op = opcodeT'(instr[15:12]);
    ctrl.cond = condT'(instr[11:9]);
    ctrl.rd = instr[11:8];
    ctrl.rs = instr[7:4];
    ctrl.rt = instr[3:0];

    case (ctrl.op)
      ADD, SUB: begin
        ctrl.regWe = 1'b1;
        ctrl.flagWe = 3'b111;
      end
      AND, NOR: begin
        ctrl.regWe = 1'b1;
        ctrl.flagWe = 3'b111;  // Overflow gets cleared
      end
      SLL, SRL, SRA: begin
        ctrl.regWe = 1'b1;
        ctrl.flagWe = 3'b111;
        ctrl.imm = {12'h000, instr[3:0]};  // Shift amount
      end
      LW: begin
        ctrl.regWe = 1'b1;
        ctrl.memRe = 1'b1;
        ctrl.imm = {{12{instr[3]}}, instr[3:0]};
      end
      SW: begin
        ctrl.memWe = 1'b1;
        ctrl.rt = instr[11:8];  // Store source sits in the rd slot
        ctrl.imm = {{12{instr[3]}}, instr[3:0]};
      end
      LHB: begin
        ctrl.regWe = 1'b1;
        ctrl.rs = instr[11:8];  // Low byte comes from rd
        ctrl.imm = {instr[7:0], 8'h00};
      end
      LLB: begin
        ctrl.regWe = 1'b1;
        ctrl.imm = {{8{instr[7]}}, instr[7:0]};
      end
      B: begin
        ctrl.imm = {{7{instr[8]}}, instr[8:0]};
      end
      JAL: begin
        ctrl.regWe = 1'b1;
        ctrl.rd = 4'd15;  // Link register
        ctrl.imm = {{4{instr[11]}}, instr[11:0]};
      end
      JR: begin
        ctrl.rs = instr[7:4];
      end
      HLT: begin
        ctrl.halt = 1'b1;
      end
      default: begin
        ctrl.regWe = 1'b0;  // Unused opcode acts as a no-op
      end
    endcase
  end

endmodule

//--- logic/regFile.sv
module regFile
  import cpuPkg::*;
(
  input  logic clk,
  input  logic rstN,
  input  logic we,
  input  logic [3:0] rs,
  input  logic [3:0] rt,
  input  logic [3:0] rd,
  input  logic [dataWidth-1:0] wdata,
  output logic [dataWidth-1:0] rsData,
  output logic [dataWidth-1:0] rtData
);

  logic [dataWidth-1:0] regs [16];

  always_ff @(posedge clk) begin
    if (!rstN) begin
      for (int i = 0; i < 16; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (rd != 4'd0)) begin
      regs[rd] <= wdata;
    end
  end

  // R0 is hardwired, no write-through bypass
  assign rsData = (rs == 4'd0) ? '0 : regs[rs];
  assign rtData = (rt == 4'd0) ? '0 : regs[rt];

endmodule

//--- logic/execute.sv
module execute
  import cpuPkg::*;
(
  input  logic clk,
  input  logic rstN,
  input  logic running,
  input  ctrlT ctrl,
  input  logic [dataWidth-1:0] rsData,
  input  logic [dataWidth-1:0] rtData,
  input  logic [dataWidth-1:0] pc,
  output logic [dataWidth-1:0] aluResult,
  output logic [dataWidth-1:0] nextPc
);

  logic [dataWidth-1:0] sum, diff, pcPlus1;
  logic addOv, subOv, taken;
  logic [2:0] flags, newFlags;
  logic [3:0] shamt;

  assign sum = rsData + rtData;
  assign diff = rsData - rtData;
  assign addOv = (rsData[15] == rtData[15]) && (sum[15] != rsData[15]);
  assign subOv = (rsData[15] != rtData[15]) && (diff[15] != rsData[15]);
  assign shamt = ctrl.imm[3:0];
  assign pcPlus1 = pc + 1'b1;

  always_comb begin
    case (ctrl.op)
      ADD: aluResult = sum;
      SUB: aluResult = diff;
      AND: aluResult = rsData & rtData;
      NOR: aluResult = ~(rsData | rtData);
      SLL: aluResult = rsData << shamt;
      SRL: aluResult = rsData >> shamt;
      SRA: aluResult = $unsigned($signed(rsData) >>> shamt);
      LW, SW: aluResult = rsData + ctrl.imm;  // Effective address
      LHB: aluResult = {ctrl.imm[15:8], rsData[7:0]};
      LLB: aluResult = ctrl.imm;
      default: aluResult = '0;
    endcase
  end

  always_comb begin
    newFlags[flagZr] = (aluResult == '0);
    newFlags[flagNe] = aluResult[15];
    newFlags[flagOv] = (ctrl.op == ADD) ? addOv : (ctrl.op == SUB) ? subOv : 1'b0;
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      flags <= '0;
    end else if (running) begin
      flags <= (flags & ~ctrl.flagWe) | (newFlags & ctrl.flagWe);
    end
  end

  // Condition is judged on flags from earlier instructions
  always_comb begin
    case (ctrl.cond)
      NEQ: taken = !flags[flagZr];
      EQ:  taken = flags[flagZr];
      GT:  taken = !flags[flagZr] && !flags[flagNe];
      LT:  taken = flags[flagNe];
      GTE: taken = flags[flagZr] || !flags[flagNe];
      LTE: taken = flags[flagZr] || flags[flagNe];
      OVF: taken = flags[flagOv];
      default: taken = 1'b1;
    endcase
  end

  always_comb begin
    case (ctrl.op)
      B: nextPc = taken ? pcPlus1 + ctrl.imm : pcPlus1;
      JAL: nextPc = pcPlus1 + ctrl.imm;
      JR: nextPc = rsData;
      default: nextPc = pcPlus1;
    endcase
  end

endmodule

//--- logic/dataMem.sv
module dataMem
  import cpuPkg::*;
(
  input  logic clk,
  input  logic running,
  input  ctrlT ctrl,
  input  logic [dataWidth-1:0] addr,
  input  logic [dataWidth-1:0] storeData,
  input  logic [dataWidth-1:0] pc,
  output logic [dataWidth-1:0] wbData,
  output outPortT outPort
);

  logic [dataWidth-1:0] mem [memDepth];
  logic [dataWidth-1:0] memData;
  logic isOut;
  logic memWr;

  assign isOut = ctrl.memWe && (addr == outPortAddr);
  assign memWr = running && ctrl.memWe && !isOut;  // Port store skips the array

  always_ff @(posedge clk) begin
    if (memWr) begin
      mem[addr[memAddrW-1:0]] <= storeData;
    end
  end

  assign memData = mem[addr[memAddrW-1:0]];

  assign outPort.valid = running && isOut;
  assign outPort.data = storeData;

  always_comb begin
    if (ctrl.memRe) begin
      wbData = memData;
    end else if (ctrl.op == JAL) begin
      wbData = pc + 1'b1;  // Return address
    end else begin
      wbData = addr;
    end
  end

endmodule

//--- logic/cpuTop.sv
module cpuTop
  import cpuPkg::*;
(
  input  logic clk,
  input  logic rstN,
  input  logic progWe,
  input  logic [dataWidth-1:0] progAddr,
  input  logic [dataWidth-1:0] progData,
  input  logic run,
  output logic halted,
  output logic [dataWidth-1:0] pc,
  output outPortT outPort
);

  logic running;
  logic [dataWidth-1:0] instr;
  logic [dataWidth-1:0] nextPc;
  logic [dataWidth-1:0] rsData, rtData;
  logic [dataWidth-1:0] aluResult;
  logic [dataWidth-1:0] wbData;
  ctrlT ctrl;

  assign halted = !running;

  programCounter i_programCounter (
    .clk(clk),
    .rstN(rstN),
    .run(run),
    .halt(ctrl.halt),
    .nextPc(nextPc),
    .pc(pc),
    .running(running)
  );

  instrMem i_instrMem (
    .clk(clk),
    .we(progWe && !running),  // Loading only while stopped
    .waddr(progAddr),
    .wdata(progData),
    .addr(pc),
    .instr(instr)
  );

  decoder i_decoder (
    .instr(instr),
    .ctrl(ctrl)
  );

  regFile i_regFile (
    .clk(clk),
    .rstN(rstN),
    .we(ctrl.regWe && running),
    .rs(ctrl.rs),
    .rt(ctrl.rt),
    .rd(ctrl.rd),
    .wdata(wbData),
    .rsData(rsData),
    .rtData(rtData)
  );

  execute i_execute (
    .clk(clk),
    .rstN(rstN),
    .running(running),
    .ctrl(ctrl),
    .rsData(rsData),
    .rtData(rtData),
    .pc(pc),
    .aluResult(aluResult),
    .nextPc(nextPc)
  );

  dataMem i_dataMem (
    .clk(clk),
    .running(running),
    .ctrl(ctrl),
    .addr(aluResult),
    .storeData(rtData),
    .pc(pc),
    .wbData(wbData),
    .outPort(outPort)
  );

endmodule

//--- include/tbProgs.svh
`ifndef TBPROGS_SVH
`define TBPROGS_SVH

// R-format, shifts and memory ops share one layout
function automatic logic [15:0] asmR(opcodeT op, logic [3:0] rd, logic [3:0] rs,
                                     logic [3:0] rt);
  return {op, rd, rs, rt};
endfunction

// LHB and LLB
function automatic logic [15:0] asmByte(opcodeT op, logic [3:0] rd, logic [7:0] imm);
  return {op, rd, imm};
endfunction

function automatic logic [15:0] asmB(condT cond, logic [8:0] offset);
  return {B, cond, offset};
endfunction

function automatic logic [15:0] asmJal(logic [11:0] offset);
  return {JAL, offset};
endfunction

function automatic logic [15:0] asmJr(logic [3:0] rs);
  return {JR, 4'h0, rs, 4'h0};
endfunction

function automatic logic [15:0] asmHlt();
  return {HLT, 12'h000};
endfunction

// LLB then LHB builds any 16-bit value
task automatic putConst(ref logic [15:0] prog[$], input logic [3:0] rd,
                        input logic [15:0] value);
  prog.push_back(asmByte(LLB, rd, value[7:0]));
  prog.push_back(asmByte(LHB, rd, value[15:8]));
endtask

// One word per cycle from address 0, driven on the falling edge
task automatic loadProg(input logic [15:0] prog[$]);
  foreach (prog[i]) begin
    @(negedge clk);
    progWe = 1'b1;
    progAddr = 16'(i);
    progData = prog[i];
  end
  @(negedge clk);
  progWe = 1'b0;
endtask

`endif

//--- bench/cpuTb.sv
module cpuTb
  import cpuPkg::*;
;

  logic clk;
  logic rstN;
  logic progWe;
  logic [15:0] progAddr;
  logic [15:0] progData;
  logic run;
  logic halted;
  logic [15:0] pc;
  outPortT outPort;

  logic [31:0] lfsr = 32'h2e05;
  int errors = 0;
  int checks = 0;

  `include "tbProgs.svh"

  cpuTop i_cpuTop (
    .clk(clk),
    .rstN(rstN),
    .progWe(progWe),
    .progAddr(progAddr),
    .progData(progData),
    .run(run),
    .halted(halted),
    .pc(pc),
    .outPort(outPort)
  );

  always #4 clk = ~clk;

  // Taps 32, 22, 2, 1
  function automatic logic stepBit();
    logic fb;
    fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
    lfsr = {lfsr[30:0], fb};
    return fb;
  endfunction

  function automatic logic [15:0] randBits(int n);
    logic [15:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[14:0], stepBit()};
    end
    return v;
  endfunction

  // Reference results for the ALU ops
  function automatic logic [15:0] refAlu(opcodeT op, logic [15:0] a, logic [15:0] b);
    logic [31:0] signFill;
    signFill = {{16{a[15]}}, a} >> b[3:0];
    case (op)
      ADD: return a + b;
      SUB: return a - b;
      AND: return a & b;
      NOR: return ~(a | b);
      SLL: return a << b[3:0];
      SRL: return a >> b[3:0];
      SRA: return signFill[15:0];  // Copies of the sign come down from the top
      default: return 16'h0000;
    endcase
  endfunction

  // Returns {zero, overflow, negative} after ADD or SUB
  function automatic logic [2:0] refFlags(opcodeT op, logic [15:0] a, logic [15:0] b);
    int wide;
    logic [15:0] res;
    wide = (op == ADD) ? $signed(a) + $signed(b) : $signed(a) - $signed(b);
    res = refAlu(op, a, b);
    return {res == 16'h0000, (wide > 32767) || (wide < -32768), res[15]};
  endfunction

  function automatic logic condHolds(condT c, logic [2:0] f);
    case (c)
      NEQ: return !f[2];
      EQ: return f[2];
      GT: return !f[2] && !f[0];
      LT: return f[0];
      GTE: return f[2] || !f[0];
      LTE: return f[2] || f[0];
      OVF: return f[1];
      default: return 1'b1;
    endcase
  endfunction

  task automatic pulseRun();
    @(negedge clk);
    run = 1'b1;
    @(negedge clk);
    run = 1'b0;
  endtask

  // Collects strobes mid-cycle until halted
  task automatic runAndCollect(ref logic [15:0] got[$]);
    int cycles;
    got.delete();
    pulseRun();
    cycles = 0;
    while (!halted && cycles < 2000) begin
      if (outPort.valid) got.push_back(outPort.data);
      @(negedge clk);
      cycles++;
    end
    if (!halted) begin
      errors++;
      $display("Timeout: processor did not halt within 2000 cycles");
    end
  endtask

  task automatic compareOutputs(ref logic [15:0] got[$], ref logic [15:0] exp[$]);
    checks++;
    assert (got.size() == exp.size()) else begin
      errors++;
      $display("[ERROR] strobe count got %h expected %h", got.size(), exp.size());
    end
    for (int i = 0; i < got.size() && i < exp.size(); i++) begin
      checks++;
      assert (got[i] == exp[i]) else begin
        errors++;
        $display("[ERROR] outPort.data[%0d] got %h expected %h", i, got[i], exp[i]);
      end
    end
  endtask

  task automatic storeOut(ref logic [15:0] prog[$], input logic [3:0] src);
    prog.push_back(asmR(SW, src, 4'd14, 4'd0));  // R14 holds the port address
  endtask

  task automatic buildArith(ref logic [15:0] prog[$], ref logic [15:0] exp[$]);
    logic [15:0] a, b;
    opcodeT ops[4] = '{ADD, SUB, AND, NOR};
    a = randBits(16);
    b = randBits(16);
    putConst(prog, 4'd14, outPortAddr);
    putConst(prog, 4'd1, a);
    putConst(prog, 4'd2, b);
    foreach (ops[i]) begin
      prog.push_back(asmR(ops[i], 4'd3, 4'd1, 4'd2));
      storeOut(prog, 4'd3);
      exp.push_back(refAlu(ops[i], a, b));
    end
    prog.push_back(asmHlt());
  endtask

  task automatic testArith();
    logic [15:0] prog[$], exp[$], got[$];
    buildArith(prog, exp);
    loadProg(prog);
    runAndCollect(got);
    compareOutputs(got, exp);
  endtask

  task automatic testShiftsBytes();
    logic [15:0] prog[$], exp[$], got[$];
    logic [15:0] a, amt;
    logic [7:0] lo, hi;
    opcodeT ops[3] = '{SLL, SRL, SRA};
    a = randBits(16);
    putConst(prog, 4'd14, outPortAddr);
    putConst(prog, 4'd1, a);
    foreach (ops[i]) begin
      amt = randBits(4);
      prog.push_back(asmR(ops[i], 4'd3, 4'd1, amt[3:0]));
      storeOut(prog, 4'd3);
      exp.push_back(refAlu(ops[i], a, amt));
    end
    lo = randBits(8);
    hi = randBits(8);
    prog.push_back(asmByte(LLB, 4'd4, lo));
    storeOut(prog, 4'd4);
    exp.push_back({{8{lo[7]}}, lo});
    prog.push_back(asmByte(LHB, 4'd4, hi));
    storeOut(prog, 4'd4);
    exp.push_back({hi, lo});
    prog.push_back(asmR(ADD, 4'd0, 4'd1, 4'd1));
    storeOut(prog, 4'd0);
    exp.push_back(16'h0000);
    prog.push_back(asmHlt());
    loadProg(prog);
    runAndCollect(got);
    compareOutputs(got, exp);
  endtask

  task automatic testMemory();
    logic [15:0] prog[$], exp[$], got[$];
    logic [15:0] addrs[3], model[logic [15:0]];
    logic [15:0] d;
    putConst(prog, 4'd14, outPortAddr);
    foreach (addrs[i]) begin
      addrs[i] = randBits(7);  // Kept below 16'h00FF
      d = randBits(16);
      model[addrs[i]] = d;
      putConst(prog, 4'd5, addrs[i]);
      putConst(prog, 4'd6, d);
      prog.push_back(asmR(SW, 4'd6, 4'd5, 4'd0));
    end
    foreach (addrs[i]) begin
      putConst(prog, 4'd5, addrs[i]);
      prog.push_back(asmR(LW, 4'd7, 4'd5, 4'd0));
      storeOut(prog, 4'd7);
      exp.push_back(model[addrs[i]]);
    end
    // Word 16'h00FF aliases the port address in the array
    putConst(prog, 4'd5, 16'h00FF);
    putConst(prog, 4'd6, 16'h1234);
    prog.push_back(asmR(SW, 4'd6, 4'd5, 4'd0));
    d = randBits(16);
    putConst(prog, 4'd6, d);
    storeOut(prog, 4'd6);
    exp.push_back(d);
    prog.push_back(asmR(LW, 4'd7, 4'd5, 4'd0));
    storeOut(prog, 4'd7);
    exp.push_back(16'h1234);
    prog.push_back(asmHlt());
    loadProg(prog);
    runAndCollect(got);
    compareOutputs(got, exp);
  endtask

  task automatic testBranches();
    logic [15:0] prog[$], exp[$], got[$];
    opcodeT ops[4] = '{SUB, SUB, SUB, ADD};
    logic [15:0] aVals[4] = '{16'd5, 16'd3, 16'd7, 16'h7FFF};
    logic [15:0] bVals[4] = '{16'd5, 16'd7, 16'd3, 16'd1};
    logic [2:0] f;
    putConst(prog, 4'd14, outPortAddr);
    putConst(prog, 4'd8, 16'hAAAA);
    putConst(prog, 4'd9, 16'h5555);
    foreach (ops[k]) begin
      putConst(prog, 4'd1, aVals[k]);
      putConst(prog, 4'd2, bVals[k]);
      prog.push_back(asmR(ops[k], 4'd3, 4'd1, 4'd2));
      f = refFlags(ops[k], aVals[k], bVals[k]);
      for (int c = 0; c < 8; c++) begin
        prog.push_back(asmB(condT'(c), 9'd1));
        storeOut(prog, 4'd8);
        storeOut(prog, 4'd9);
        if (!condHolds(condT'(c), f)) exp.push_back(16'hAAAA);
        exp.push_back(16'h5555);
      end
    end
    prog.push_back(asmHlt());
    loadProg(prog);
    runAndCollect(got);
    compareOutputs(got, exp);
  endtask

  task automatic testJumps();
    logic [15:0] prog[$], exp[$], got[$];
    int jalAddr;
    putConst(prog, 4'd14, outPortAddr);
    putConst(prog, 4'd9, 16'h5555);
    jalAddr = prog.size();
    prog.push_back(asmJal(12'd2));
    storeOut(prog, 4'd9);  // Reached only on return
    prog.push_back(asmHlt());
    storeOut(prog, 4'd15);
    prog.push_back(asmJr(4'd15));
    exp.push_back(16'(jalAddr + 1));
    exp.push_back(16'h5555);
    loadProg(prog);
    runAndCollect(got);
    compareOutputs(got, exp);
  endtask

  task automatic testHaltRestart();
    logic [15:0] prog[$], exp[$], got[$];
    logic [15:0] hltAddr;
    buildArith(prog, exp);
    hltAddr = 16'(prog.size() - 1);
    loadProg(prog);
    for (int r = 0; r < 2; r++) begin
      runAndCollect(got);
      compareOutputs(got, exp);
      checks++;
      assert (pc == hltAddr + 16'd1) else begin
        errors++;
        $display("[ERROR] pc got %h expected %h", pc, hltAddr + 16'd1);
      end
      repeat (20) begin
        @(negedge clk);
        checks++;
        assert (halted && !outPort.valid) else begin
          errors++;
          $display("Processor left the halted state or strobed while halted");
        end
      end
    end
  endtask

  initial begin
    clk = 1'b0;
    rstN = 1'b0;
    progWe = 1'b0;
    progAddr = '0;
    progData = '0;
    run = 1'b0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rstN = 1'b1;
    checks++;
    assert (halted && pc == 16'h0000 && !outPort.valid) else begin
      errors++;
      $display("Processor not halted at pc 0 after reset");
    end
    testArith();
    testShiftsBytes();
    testMemory();
    testBranches();
    testJumps();
    testHaltRestart();
    $display("Checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- sources.f
+incdir+include
logic/cpuPkg.sv
logic/programCounter.sv
logic/instrMem.sv
logic/decoder.sv
logic/regFile.sv
logic/execute.sv
logic/dataMem.sv
logic/cpuTop.sv
bench/cpuTb.sv

//--- run.sh
#!/bin/sh
# Build and run the testbench, then look for the pass line in its output
cd "$(dirname "$0")" &&
verilator --binary --timing -f sources.f --top-module cpuTb &&
./obj_dir/VcpuTb | tee /dev/stderr | grep -q "ALL TESTS PASSED" || exit 1
exit 0
